//--- verilog.f
+incdir+.
exec_pkg.sv
exec_op_if.sv
exec_result_if.sv
exec_decode.sv
exec_regfile.sv
exec_alu.sv
exec_retire.sv
exec_top.sv
tb_clock_gen.sv
tb_exec_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP := tb_exec_top
FILELIST := verilog.f
BUILD_DIR := obj_dir

SIM := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := exec_config.svh

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source, the header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- tb_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module tb_exec_top;
	localparam int NUM_INSTR = 400;
	localparam int RESET_CYCLES = 16;
	localparam int TIMEOUT_CYCLES = NUM_INSTR * 8 + RESET_CYCLES;

	logic clock;
	logic reset;
	logic instr_valid;
	logic [31:0] instr;
	logic ready;
	logic instr_complete;
	logic [`EXEC_XLEN-1:0] pc;
	logic rd_wen;
	logic [4:0] rd_addr;
	logic [`EXEC_XLEN-1:0] rd_wdata;

	integer seed;
	int cycle_count;
	int completions;
	int sent;
	logic [`EXEC_XLEN-1:0] model_regs [`EXEC_REGS];
	logic [`EXEC_XLEN-1:0] model_pc;
	logic [31:0] next_word;
	logic exp_wen;
	logic [4:0] exp_rd;
	logic [`EXEC_XLEN-1:0] exp_data;
	logic [`EXEC_XLEN-1:0] exp_pc;
	bit seen_taken [6];
	bit seen_not_taken [6];

	tb_clock_gen i_clock_gen (.clock(clock));

	exec_top i_dut (
		.clock(clock),
		.reset(reset),
		.instr_valid(instr_valid),
		.instr(instr),
		.ready(ready),
		.instr_complete(instr_complete),
		.pc(pc),
		.rd_wen(rd_wen),
		.rd_addr(rd_addr),
		.rd_wdata(rd_wdata)
	);

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else
			report_failure($sformatf("MISMATCH at %0t: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	// kind numbers run add sub and or xor slt sltu, then the six immediate forms,
	// the six branches and one other opcode
	function automatic logic [2:0] kind_funct3(input int kind);
		case (kind)
			0, 1, 7, 13: return 3'b000;
			14: return 3'b001;
			5, 11: return 3'b010;
			6, 12: return 3'b011;
			4, 10, 15: return 3'b100;
			16: return 3'b101;
			3, 9, 17: return 3'b110;
			default: return 3'b111;
		endcase
	endfunction

	function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic sub,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: return sub ? a - b : a + b;
			3'b010: return {31'b0, $signed(a) < $signed(b)};
			3'b011: return {31'b0, a < b};
			3'b100: return a ^ b;
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic ref_branch(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// draws instruction n and works out what the model expects from it
	task automatic make_instr(input int n);
		exec_pkg::instr_u w;
		logic [31:0] r;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		logic [11:0] imm;
		logic [12:0] off;
		logic same;
		logic [2:0] f3;
		logic taken;
		int kind;
		r = $random(seed);
		kind = int'(r[7:0]) % 20;
		rs1 = r[12:8];
		rs2 = r[17:13];
		rd = r[22:18];
		same = r[23];
		r = $random(seed);
		imm = r[11:0];
		off = {r[23:12], 1'b0};
		if (n < 31) begin	// addi xn, x0, imm fills the registers
			kind = 7;
			rs1 = 5'd0;
			rd = 5'(n + 1);
		end else if (n == 31) begin	// write to x0 must be dropped
			kind = 7;
			rs1 = 5'd1;
			rd = 5'd0;
		end else if (n == 32) begin	// or x3, x0, x0
			kind = 3;
			rs1 = 5'd0;
			rs2 = 5'd0;
			rd = 5'd3;
		end
		if (kind >= 13 && kind < 19 && same)
			rs2 = rs1;	// equal operands
		f3 = kind_funct3(kind);
		exp_wen = 1'b0;
		exp_rd = rd;
		exp_data = '0;
		exp_pc = model_pc + 32'd4;
		w = '0;
		if (kind < 7) begin
			w.r.opcode = exec_pkg::OPC_OP;
			w.r.funct7 = (kind == 1) ? 7'b0100000 : 7'b0000000;
			w.r.rs2 = rs2;
			w.r.rs1 = rs1;
			w.r.funct3 = f3;
			w.r.rd = rd;
			exp_wen = 1'b1;
			exp_data = ref_alu(f3, kind == 1, model_regs[rs1], model_regs[rs2]);
		end else if (kind < 13) begin
			w.i.opcode = exec_pkg::OPC_OP_IMM;
			w.i.imm = imm;
			w.i.rs1 = rs1;
			w.i.funct3 = f3;
			w.i.rd = rd;
			exp_wen = 1'b1;
			exp_data = ref_alu(f3, 1'b0, model_regs[rs1], {{20{imm[11]}}, imm});
		end else if (kind < 19) begin
			w.b.opcode = exec_pkg::OPC_BRANCH;
			w.b.rs1 = rs1;
			w.b.rs2 = rs2;
			w.b.funct3 = f3;
			w.b.imm12 = off[12];
			w.b.imm11 = off[11];
			w.b.imm10_5 = off[10:5];
			w.b.imm4_1 = off[4:1];
			taken = ref_branch(f3, model_regs[rs1], model_regs[rs2]);
			if (taken) begin
				exp_pc = model_pc + {{19{off[12]}}, off};
				seen_taken[kind - 13] = 1'b1;
			end else begin
				seen_not_taken[kind - 13] = 1'b1;
			end
		end else begin
			w = r;
			w.r.opcode = 7'b0110111;	// lui retires as a no-op here
		end
		next_word = w;
	endtask

	// called at a rising edge and returns at the edge that ends the completion cycle
	task automatic run_instr(input logic hold);
		int lat;
		instr_valid <= 1'b1;
		instr <= next_word;
		@(negedge clock);
		while (!ready)
			@(negedge clock);
		@(posedge clock);	// accepted here
		if (!hold)
			instr_valid <= 1'b0;
		lat = 0;
		do begin
			@(negedge clock);
			lat++;
			assert (!ready) else report_failure("ready went high while an instruction was busy");
		end while (!instr_complete && lat < 4);
		assert (lat == 3) else
			report_failure($sformatf("no completion exactly 3 cycles after acceptance (%0d)", lat));
		check_value("rd_wen", 32'(rd_wen), 32'(exp_wen));
		if (exp_wen) begin
			check_value("rd_addr", 32'(rd_addr), 32'(exp_rd));
			check_value("rd_wdata", rd_wdata, exp_data);
		end
		check_value("pc", pc, exp_pc);
		model_pc = exp_pc;
		if (exp_wen && exp_rd != 5'd0)
			model_regs[exp_rd] = exp_data;
		sent++;
		@(posedge clock);
		assert (completions == sent) else
			report_failure($sformatf("%0d completions seen after %0d instructions",
				completions, sent));
	endtask

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
			report_failure($sformatf("timeout, the run did not finish in %0d cycles", cycle_count));
	end

	always @(negedge clock) begin
		if (!reset && instr_complete)
			completions++;
	end

	initial begin
		logic [31:0] draw;
		int gap;
		seed = 54;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		sent = 0;
		model_pc = `EXEC_RESET_PC;
		for (int i = 0; i < `EXEC_REGS; i++)
			model_regs[i] = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_value("pc", pc, `EXEC_RESET_PC);
		check_value("ready", 32'(ready), 32'd1);
		check_value("instr_complete", 32'(instr_complete), 32'd0);
		@(posedge clock);
		for (int n = 0; n < NUM_INSTR; n++) begin
			draw = $random(seed);
			gap = int'(draw[1:0]);
			make_instr(n);
			if (gap > 0) begin
				instr_valid <= 1'b0;
				repeat (gap) @(posedge clock);
			end
			run_instr(draw[2]);	// sometimes instr_valid stays up while busy
		end
		instr_valid <= 1'b0;
		repeat (4) @(posedge clock);
		for (int k = 0; k < 6; k++)
			assert (seen_taken[k] && seen_not_taken[k]) else
				report_failure($sformatf("branch kind %0d did not see both outcomes", k));
		if (completions == NUM_INSTR) begin
			$display("All tests passed!");
			$finish;
		end else begin
			report_failure($sformatf("%0d completions for %0d instructions",
				completions, NUM_INSTR));
		end
	end
endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clock
);
	initial clock = 1'b0;

	always #50 clock = ~clock;	// 100 ns period
endmodule

`default_nettype wire

//--- exec_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module exec_top (
	input logic clock,
	input logic reset,
	input logic instr_valid,
	input logic [31:0] instr,
	output logic ready,
	output logic instr_complete,
	output logic [`EXEC_XLEN-1:0] pc,
	output logic rd_wen,
	output logic [$clog2(`EXEC_REGS)-1:0] rd_addr,
	output logic [`EXEC_XLEN-1:0] rd_wdata
);
	logic [$clog2(`EXEC_REGS)-1:0] rs1_addr;
	logic [$clog2(`EXEC_REGS)-1:0] rs2_addr;
	logic [`EXEC_XLEN-1:0] rs1_data;
	logic [`EXEC_XLEN-1:0] rs2_data;

	exec_op_if op_if ();
	exec_result_if res_if ();

	exec_decode i_decode (
		.clock(clock),
		.reset(reset),
		.instr_valid(instr_valid),
		.instr(instr),
		.pc(pc),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.ready(ready),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.op(op_if.decode)
	);

	exec_regfile i_regfile (
		.clock(clock),
		.reset(reset),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.wr_en(rd_wen),	// write-back lands at the completion edge
		.wr_addr(rd_addr),
		.wr_data(rd_wdata),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data)
	);

	exec_alu i_alu (
		.clock(clock),
		.reset(reset),
		.op(op_if.exec),
		.res(res_if.exec)
	);

	exec_retire i_retire (
		.clock(clock),
		.reset(reset),
		.res(res_if.retire),
		.op(op_if.retire),
		.pc(pc),
		.wr_en(rd_wen),
		.wr_addr(rd_addr),
		.wr_data(rd_wdata),
		.instr_complete(instr_complete)
	);
endmodule

`default_nettype wire

//--- exec_retire.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module exec_retire (
	input logic clock,
	input logic reset,
	exec_result_if.retire res,
	exec_op_if.retire op,
	output logic [`EXEC_XLEN-1:0] pc,
	output logic wr_en,
	output logic [$clog2(`EXEC_REGS)-1:0] wr_addr,
	output logic [`EXEC_XLEN-1:0] wr_data,
	output logic instr_complete
);
	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= `EXEC_RESET_PC;
			wr_en <= 1'b0;
			instr_complete <= 1'b0;
		end else begin
			instr_complete <= res.valid;	// one pulse per result
			wr_en <= res.valid && res.wr_en;
			if (res.valid)
				pc <= res.next_pc;
		end
	end

	always_ff @(posedge clock) begin
		if (res.valid) begin
			wr_addr <= res.rd;
			wr_data <= res.wdata;
		end
	end

	// decode drops its valid while this is high
	assign op.complete = instr_complete;
endmodule

`default_nettype wire

//--- exec_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module exec_alu (
	input logic clock,
	input logic reset,
	exec_op_if.exec op,
	exec_result_if.exec res
);
	logic issued;
	logic issue;
	logic cmp;
	logic taken;
	logic [`EXEC_XLEN-1:0] result;
	logic [`EXEC_XLEN-1:0] next_pc;

	assign issue = op.valid && !issued;

	always_comb begin
		case (op.op)
			exec_pkg::ALU_LT: cmp = $signed(op.op_a) < $signed(op.op_b);
			exec_pkg::ALU_LTU: cmp = op.op_a < op.op_b;
			exec_pkg::ALU_EQ: cmp = op.op_a == op.op_b;
			default: cmp = 1'b0;
		endcase
	end

	always_comb begin
		case (op.op)
			exec_pkg::ALU_ADD: result = op.op_a + op.op_b;
			exec_pkg::ALU_SUB: result = op.op_a - op.op_b;
			exec_pkg::ALU_AND: result = op.op_a & op.op_b;
			exec_pkg::ALU_OR: result = op.op_a | op.op_b;
			exec_pkg::ALU_XOR: result = op.op_a ^ op.op_b;
			exec_pkg::ALU_LT, exec_pkg::ALU_LTU: result = {{(`EXEC_XLEN-1){1'b0}}, cmp};
			default: result = '0;
		endcase
	end

	// invert turns eq/lt/ltu into ne/ge/geu
	assign taken = (op.op_type == exec_pkg::OP_BRANCH) && (cmp ^ op.invert);
	assign next_pc = taken ? op.pc + op.op_c : op.pc + `EXEC_XLEN'(4);

	always_ff @(posedge clock) begin
		if (reset) begin
			issued <= 1'b0;
			res.valid <= 1'b0;
		end else begin
			res.valid <= issue;
			if (issue)
				issued <= 1'b1;
			else if (op.complete)
				issued <= 1'b0;	// ready for the next held op
		end
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			res.wr_en <= (op.op_type == exec_pkg::OP_ALU);
			res.rd <= op.rd;
			res.wdata <= result;
			res.next_pc <= next_pc;
		end
	end
endmodule

`default_nettype wire

//--- exec_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module exec_regfile (
	input logic clock,
	input logic reset,
	input logic [$clog2(`EXEC_REGS)-1:0] rs1_addr,
	input logic [$clog2(`EXEC_REGS)-1:0] rs2_addr,
	input logic wr_en,
	input logic [$clog2(`EXEC_REGS)-1:0] wr_addr,
	input logic [`EXEC_XLEN-1:0] wr_data,
	output logic [`EXEC_XLEN-1:0] rs1_data,
	output logic [`EXEC_XLEN-1:0] rs2_data
);
	logic [`EXEC_XLEN-1:0] regs [`EXEC_REGS];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `EXEC_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_addr != '0) begin	// x0 stays zero
			regs[wr_addr] <= wr_data;
		end
	end

	// reads are combinational so decode captures in the accept cycle
	assign rs1_data = regs[rs1_addr];
	assign rs2_data = regs[rs2_addr];
endmodule

`default_nettype wire

//--- exec_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module exec_decode (
	input logic clock,
	input logic reset,
	input logic instr_valid,
	input logic [31:0] instr,
	input logic [`EXEC_XLEN-1:0] pc,
	input logic [`EXEC_XLEN-1:0] rs1_data,
	input logic [`EXEC_XLEN-1:0] rs2_data,
	output logic ready,
	output logic [$clog2(`EXEC_REGS)-1:0] rs1_addr,
	output logic [$clog2(`EXEC_REGS)-1:0] rs2_addr,
	exec_op_if.decode op
);
	typedef enum logic {S_IDLE, S_BUSY} state_e;

	state_e state;
	exec_pkg::instr_u word;
	exec_pkg::op_type_e dec_type;
	exec_pkg::alu_op_e dec_op;
	logic dec_invert;
	logic [`EXEC_XLEN-1:0] imm_i;
	logic [`EXEC_XLEN-1:0] imm_b;
	logic take;

	assign word = instr;
	assign rs1_addr = word.r.rs1;	// rs2 sits in the same place for B
	assign rs2_addr = word.r.rs2;
	assign ready = (state == S_IDLE);
	assign take = ready && instr_valid;
	assign op.valid = (state == S_BUSY) && !op.complete;

	assign imm_i = {{(`EXEC_XLEN-12){word.i.imm[11]}}, word.i.imm};
	assign imm_b = {{(`EXEC_XLEN-12){word.b.imm12}}, word.b.imm11, word.b.imm10_5,
		word.b.imm4_1, 1'b0};

	always_comb begin
		dec_type = exec_pkg::OP_NONE;
		dec_op = exec_pkg::ALU_ADD;
		dec_invert = 1'b0;
		if (word.r.opcode == exec_pkg::OPC_OP || word.r.opcode == exec_pkg::OPC_OP_IMM) begin
			dec_type = exec_pkg::OP_ALU;
			case (word.r.funct3)
				3'b000: begin	// sub only exists in register form
					if (word.r.opcode == exec_pkg::OPC_OP && word.r.funct7[5])
						dec_op = exec_pkg::ALU_SUB;
				end
				3'b010: dec_op = exec_pkg::ALU_LT;
				3'b011: dec_op = exec_pkg::ALU_LTU;
				3'b100: dec_op = exec_pkg::ALU_XOR;
				3'b110: dec_op = exec_pkg::ALU_OR;
				3'b111: dec_op = exec_pkg::ALU_AND;
				default: dec_type = exec_pkg::OP_NONE;	// shifts retire as no-op
			endcase
		end else if (word.b.opcode == exec_pkg::OPC_BRANCH) begin
			dec_type = exec_pkg::OP_BRANCH;
			dec_invert = word.b.funct3[0];	// bne, bge, bgeu
			case (word.b.funct3[2:1])
				2'b00: dec_op = exec_pkg::ALU_EQ;
				2'b10: dec_op = exec_pkg::ALU_LT;
				2'b11: dec_op = exec_pkg::ALU_LTU;
				default: dec_type = exec_pkg::OP_NONE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset)
			state <= S_IDLE;
		else if (take)
			state <= S_BUSY;
		else if (op.complete)
			state <= S_IDLE;
	end

	always_ff @(posedge clock) begin
		if (take) begin
			op.op_type <= dec_type;
			op.op <= dec_op;
			op.invert <= dec_invert;
			op.op_a <= rs1_data;
			op.op_b <= (word.i.opcode == exec_pkg::OPC_OP_IMM) ? imm_i : rs2_data;
			op.op_c <= imm_b;
			op.pc <= pc;
			op.rd <= word.r.rd;
		end
	end
endmodule

`default_nettype wire

//--- exec_result_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

interface exec_result_if;
	logic valid;	// single cycle
	logic wr_en;
	logic [$clog2(`EXEC_REGS)-1:0] rd;
	logic [`EXEC_XLEN-1:0] wdata;
	logic [`EXEC_XLEN-1:0] next_pc;

	modport exec (output valid, wr_en, rd, wdata, next_pc);
	modport retire (input valid, wr_en, rd, wdata, next_pc);
endinterface

`default_nettype wire

//--- exec_op_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

interface exec_op_if;
	logic valid;	// held until complete
	exec_pkg::op_type_e op_type;
	exec_pkg::alu_op_e op;
	logic [`EXEC_XLEN-1:0] op_a;
	logic [`EXEC_XLEN-1:0] op_b;
	logic [`EXEC_XLEN-1:0] op_c;	// branch offset
	logic invert;
	logic [`EXEC_XLEN-1:0] pc;
	logic [$clog2(`EXEC_REGS)-1:0] rd;
	logic complete;

	modport decode (output valid, op_type, op, op_a, op_b, op_c, invert, pc, rd, input complete);
	modport exec (input valid, op_type, op, op_a, op_b, op_c, invert, pc, rd, complete);
	modport retire (output complete);
endinterface

`default_nettype wire

//--- exec_pkg.sv
`default_nettype none

package exec_pkg;

	localparam logic [6:0] OPC_OP = 7'b0110011;	// register-register
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;	// register-immediate
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	typedef enum logic [1:0] {OP_NONE, OP_ALU, OP_BRANCH} op_type_e;

	// eq, lt and ltu double as branch compares
	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_LT, ALU_LTU, ALU_EQ
	} alu_op_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} instr_r_s;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} instr_i_s;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		logic [6:0] opcode;
	} instr_b_s;

	typedef union packed {
		instr_r_s r;
		instr_i_s i;
		instr_b_s b;
	} instr_u;

endpackage

`default_nettype wire

//--- exec_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// data path and pc width
`define EXEC_XLEN 32

// architectural registers, x0 included
`define EXEC_REGS 32

// first pc after reset
`define EXEC_RESET_PC 32'h8000_0000

`endif
